// File: project.f
src/csr_pkg.sv
src/csr_machine_regs.sv
src/csr_command_stage.sv
src/csr_trap_unit.sv
src/csr_read_mux.sv
src/csr_stage_top.sv
verif/csr_checker.sv
verif/tb_csr_stage.sv

// File: verif/tb_csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_stage;

    import csr_pkg::*;

    localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
    localparam int REQUEST_COUNT = 400;
    // Two cycles per request plus margin
    localparam int TIMEOUT_CYCLES = 2 * REQUEST_COUNT + 700;

    logic        clk;
    logic        reset;
    logic [63:0] cycle_count;
    logic [63:0] time_count;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        flush;
    logic        interrupt_ready;
    csr_cmd_e    csr_cmd;
    logic [31:0] op1_data;
    logic [31:0] imm_i;
    logic [31:0] fetch_pc;
    csr_cmd_e    cmd_out;
    logic [31:0] rdata;
    logic [31:0] trap_vector;
    logic        stall_may_interrupt;
    int          error_count;
    int          check_count;
    int          cycle_counter = 0;
    logic [31:0] rng_state = 32'd3;

    csr_stage_top #(.MTVEC_RESET(MTVEC_RESET)) u_csr_stage_top (.*);

    csr_checker #(.MTVEC_RESET(MTVEC_RESET)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [11:0] rmw_target(input logic [31:0] r);
        case (r % 6)
            0:       return CSR_ADDR_MSCRATCH;
            1:       return CSR_ADDR_MTVEC;
            2:       return CSR_ADDR_MTVAL;
            3:       return CSR_ADDR_MEPC;
            4:       return CSR_ADDR_MCOUNTEREN;
            default: return CSR_ADDR_SCOUNTEREN;
        endcase
    endfunction

    task automatic drive_idle();
        csr_cmd  = CSR_X;
        imm_i    = '0;
        op1_data = '0;
        flush    = 1'b0;
    endtask

    // One request, then one idle cycle so a following read sees the write
    task automatic send_request(input csr_cmd_e cmd, input logic [11:0] addr,
                                input logic [31:0] op1);
        logic [31:0] upper;
        upper    = rand_word();
        csr_cmd  = cmd;
        imm_i    = {upper[31:12], addr};
        op1_data = op1;
        @(posedge clk);
        #0.5;
        drive_idle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic take_interrupt(input logic [31:0] pc);
        interrupt_ready = 1'b1;
        fetch_pc        = pc;
        @(posedge clk);
        #0.5;
        interrupt_ready = 1'b0;
        @(posedge clk);
        #0.5;
    endtask

    // Counters advance in both halves
    always @(posedge clk) begin
        #0.5;
        cycle_count = cycle_count + 64'h0000_0001_0000_0001;
        time_count  = time_count + 64'h0000_0003_0000_0005;
    end

    always @(posedge clk) begin
        cycle_counter = cycle_counter + 1;
        if (cycle_counter >= TIMEOUT_CYCLES) begin
            $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks run: %0d, errors: %0d", check_count, error_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [11:0] addr;
        logic [31:0] value;
        csr_cmd_e    cmd;
        priv_mode_e  target;
        reset           = 1'b1;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        mtime           = '0;
        mtimecmp        = '1;
        cycle_count     = 64'h0000_0005_ffff_fff0;
        time_count      = 64'h0000_0100_0000_0000;
        drive_idle();
        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // Random read-modify-write to plain registers
        repeat (100) begin
            value = rand_word();
            addr  = rmw_target(value);
            cmd   = csr_cmd_e'(3'(1 + (value >> 8) % 3));
            send_request(cmd, addr, rand_word());
            send_request(CSR_X, addr, '0);
        end

        // Only kept fields of mstatus and mie survive
        repeat (20) begin
            send_request(CSR_W, CSR_ADDR_MSTATUS, rand_word());
            send_request(CSR_X, CSR_ADDR_MSTATUS, '0);
            value = rand_word();
            send_request(csr_cmd_e'(3'(1 + value % 3)), CSR_ADDR_MIE, rand_word());
            send_request(CSR_X, CSR_ADDR_MIE, '0);
        end

        // MRET into each mode, counter access, then ECALL back
        for (int round = 0; round < 6; round++) begin
            target = (round % 3 == 2) ? MODE_MACHINE : priv_mode_e'(2'(round % 3));
            send_request(CSR_W, CSR_ADDR_MCOUNTEREN, rand_word());
            send_request(CSR_W, CSR_ADDR_SCOUNTEREN, rand_word());
            send_request(CSR_W, CSR_ADDR_MEPC, rand_word() & 32'hffff_fffc);
            value = (rand_word() & 32'h0000_0088) | (32'(target) << 11);
            send_request(CSR_W, CSR_ADDR_MSTATUS, value);
            send_request(CSR_MRET, '0, '0);
            send_request(CSR_X, CSR_ADDR_CYCLE, '0);
            send_request(CSR_X, CSR_ADDR_CYCLEH, '0);
            send_request(CSR_X, CSR_ADDR_TIME, '0);
            send_request(CSR_X, CSR_ADDR_TIMEH, '0);
            send_request(CSR_ECALL, '0, '0);
            send_request(CSR_X, CSR_ADDR_MCAUSE, '0);
            send_request(CSR_X, CSR_ADDR_MSTATUS, '0);
        end

        // Timer interrupt from user mode
        send_request(CSR_W, CSR_ADDR_MIE, 32'h0000_0080);
        send_request(CSR_W, CSR_ADDR_MTVEC, rand_word() & 32'hffff_fffc);
        send_request(CSR_W, CSR_ADDR_MSTATUS, 32'h0);
        send_request(CSR_MRET, '0, '0);
        mtimecmp = 64'h0000_0001_0000_0000;
        mtime    = mtimecmp - 64'd1;
        send_request(CSR_X, '0, '0);
        mtime = mtimecmp;
        send_request(CSR_X, '0, '0);
        take_interrupt(rand_word());
        send_request(CSR_X, CSR_ADDR_MEPC, '0);
        send_request(CSR_X, CSR_ADDR_MCAUSE, '0);
        send_request(CSR_X, CSR_ADDR_MSTATUS, '0);

        // Machine mode stays masked until MIE is set
        send_request(CSR_X, '0, '0);
        send_request(CSR_W, CSR_ADDR_MSTATUS, 32'h0000_1808);
        send_request(CSR_X, '0, '0);
        take_interrupt(rand_word());
        send_request(CSR_X, CSR_ADDR_MEPC, '0);
        send_request(CSR_X, CSR_ADDR_MCAUSE, '0);
        send_request(CSR_X, CSR_ADDR_MSTATUS, '0);
        mtime = '0;

        // Squashed writes leave mscratch alone
        repeat (10) begin
            flush = 1'b1;
            send_request(CSR_W, CSR_ADDR_MSCRATCH, rand_word());
            send_request(CSR_X, CSR_ADDR_MSCRATCH, '0);
        end

        @(negedge clk);
        #0.5;
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [63:0]        cycle_count,
    input  wire logic [63:0]        time_count,
    input  wire logic [63:0]        mtime,
    input  wire logic [63:0]        mtimecmp,
    input  wire logic               flush,
    input  wire logic               interrupt_ready,
    input  wire csr_pkg::csr_cmd_e  csr_cmd,
    input  wire logic [31:0]        op1_data,
    input  wire logic [31:0]        imm_i,
    input  wire logic [31:0]        fetch_pc,
    input  wire csr_pkg::csr_cmd_e  cmd_out,
    input  wire logic [31:0]        rdata,
    input  wire logic [31:0]        trap_vector,
    input  wire logic               stall_may_interrupt,
    output int                      error_count,
    output int                      check_count
);

    import csr_pkg::*;

    typedef struct packed {
        logic [2:0]  cmd;
        logic [31:0] rdata;
        logic [31:0] trap_vector;
    } expect_t;

    // Model of the kept CSRs and the privilege mode
    logic [1:0]  mode;
    logic [1:0]  st_mpp;
    logic        st_mie;
    logic        st_mpie;
    logic        st_mprv;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mtval;
    logic [31:0] mie_reg;
    logic [2:0]  mcounteren;
    logic [2:0]  scounteren;
    // Request held for the write half of read-modify-write
    logic [2:0]  save_cmd;
    logic [11:0] save_addr;
    logic [31:0] save_op1;
    expect_t     exp_out;
    logic        started = 1'b0;

    function automatic logic counter_ok(input logic m_en, input logic s_en);
        return (mode == MODE_MACHINE) || (mode == MODE_SUPERVISOR && m_en) ||
               (mode == MODE_USER && m_en && s_en);
    endfunction

    function automatic logic [31:0] status_word();
        logic [31:0] w;
        w        = '0;
        w[17]    = st_mprv;
        w[12:11] = st_mpp;
        w[7]     = st_mpie;
        w[3]     = st_mie;
        return w;
    endfunction

    function automatic logic [31:0] read_model(input logic [11:0] addr);
        logic cy_ok;
        logic tm_ok;
        cy_ok = counter_ok(mcounteren[0], scounteren[0]);
        tm_ok = counter_ok(mcounteren[1], scounteren[1]);
        case (addr)
            CSR_ADDR_CYCLE:      return cy_ok ? cycle_count[31:0] : 32'b0;
            CSR_ADDR_CYCLEH:     return cy_ok ? cycle_count[63:32] : 32'b0;
            CSR_ADDR_TIME:       return tm_ok ? time_count[31:0] : 32'b0;
            CSR_ADDR_TIMEH:      return tm_ok ? time_count[63:32] : 32'b0;
            CSR_ADDR_MSTATUS:    return status_word();
            CSR_ADDR_MIE:        return mie_reg;
            CSR_ADDR_MTVEC:      return mtvec;
            CSR_ADDR_MCOUNTEREN: return {29'b0, mcounteren};
            CSR_ADDR_SCOUNTEREN: return {29'b0, scounteren};
            CSR_ADDR_MSCRATCH:   return mscratch;
            CSR_ADDR_MEPC:       return mepc;
            CSR_ADDR_MCAUSE:     return mcause;
            CSR_ADDR_MTVAL:      return mtval;
            default:             return 32'b0;
        endcase
    endfunction

    function automatic logic timer_pending();
        return (mtime >= mtimecmp) && mie_reg[7] && (mode != MODE_MACHINE || st_mie);
    endfunction

    // Advances the model by one rising edge and returns the expected outputs
    function automatic expect_t predict_edge();
        expect_t     e;
        logic [2:0]  cmd;
        logic [11:0] addr;
        logic [31:0] op1;
        logic [31:0] wdata;
        logic [1:0]  old_mode;
        logic [1:0]  old_mpp;
        logic        take;
        cmd  = flush ? CSR_X : csr_cmd;
        addr = flush ? 12'hfff : imm_i[11:0];
        op1  = flush ? 32'hffff_ffff : op1_data;
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = exp_out.rdata | save_op1;
            CSR_C:   wdata = exp_out.rdata & ~save_op1;
            default: wdata = 32'b0;
        endcase
        take          = timer_pending() && interrupt_ready;
        old_mode      = mode;
        old_mpp       = st_mpp;
        e.rdata       = read_model(addr);
        e.cmd         = take ? CSR_ECALL : cmd;
        e.trap_vector = exp_out.trap_vector;
        if (take || cmd == CSR_ECALL) begin
            e.trap_vector = mtvec;
            mode          = MODE_MACHINE;
            st_mpp        = old_mode;
            st_mpie       = st_mie;
            st_mie        = 1'b0;
            // Timer takes the place of any ECALL presented with it
            if (take) begin
                mepc   = fetch_pc;
                mcause = MCAUSE_MTIMER;
            end else begin
                mcause = MCAUSE_ECALL_BASE + 32'(old_mode);
            end
        end else if (cmd == CSR_MRET) begin
            e.trap_vector = mepc;
            mode          = old_mpp;
            st_mpp        = MODE_USER;
            st_mie        = st_mpie;
            st_mpie       = 1'b1;
            if (old_mpp != MODE_MACHINE) begin
                st_mprv = 1'b0;
            end
        end
        // Software write lands after the trap updates
        if (save_cmd inside {CSR_W, CSR_S, CSR_C}) begin
            case (save_addr)
                CSR_ADDR_MSTATUS: begin
                    st_mprv = wdata[17];
                    st_mpie = wdata[7];
                    st_mie  = wdata[3];
                    // MPP takes legal modes only
                    if (wdata[12:11] != 2'b10) begin
                        st_mpp = wdata[12:11];
                    end
                end
                CSR_ADDR_MEPC:       mepc       = wdata;
                CSR_ADDR_MCAUSE:     mcause     = wdata;
                CSR_ADDR_MTVEC:      mtvec      = wdata;
                CSR_ADDR_MSCRATCH:   mscratch   = wdata;
                CSR_ADDR_MTVAL:      mtval      = wdata;
                CSR_ADDR_MIE:        mie_reg    = wdata & 32'h0000_0888;
                CSR_ADDR_MCOUNTEREN: mcounteren = wdata[2:0];
                CSR_ADDR_SCOUNTEREN: scounteren = wdata[2:0];
                default: ;
            endcase
        end
        save_cmd  = cmd;
        save_addr = addr;
        save_op1  = op1;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: expected 0x%h, got 0x%h", $time, name, expected, got);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            mode       = MODE_MACHINE;
            st_mpp     = MODE_MACHINE;
            st_mie     = 1'b0;
            st_mpie    = 1'b0;
            st_mprv    = 1'b0;
            mepc       = '0;
            mcause     = '0;
            mtvec      = MTVEC_RESET;
            mscratch   = '0;
            mtval      = '0;
            mie_reg    = '0;
            mcounteren = '0;
            scounteren = '0;
            save_cmd   = CSR_X;
            exp_out    = '0;
            started    = 1'b1;
        end else begin
            exp_out = predict_edge();
        end
    end

    // Registered outputs and inputs are all settled by the falling edge
    always @(negedge clk) begin
        if (started) begin
            check_value("cmd_out", 32'(cmd_out), 32'(exp_out.cmd));
            check_value("rdata", rdata, exp_out.rdata);
            check_value("trap_vector", trap_vector, exp_out.trap_vector);
            check_value("stall_may_interrupt", 32'(stall_may_interrupt), 32'(timer_pending()));
        end
    end

endmodule

`default_nettype wire

// File: src/csr_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage_top #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [63:0]        cycle_count,
    input  wire logic [63:0]        time_count,
    input  wire logic [63:0]        mtime,
    input  wire logic [63:0]        mtimecmp,
    input  wire logic               flush,
    input  wire logic               interrupt_ready,
    input  wire csr_pkg::csr_cmd_e  csr_cmd,
    input  wire logic [31:0]        op1_data,
    input  wire logic [31:0]        imm_i,
    input  wire logic [31:0]        fetch_pc,
    output csr_pkg::csr_cmd_e       cmd_out,
    output logic [31:0]             rdata,
    output logic [31:0]             trap_vector,
    output logic                    stall_may_interrupt
);

    import csr_pkg::*;

    csr_req_t      req;
    csr_write_t    wr;
    machine_csrs_t mcsr;
    trap_state_t   tstate;

    // Squash and read-modify-write sequencing
    csr_command_stage u_command (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .csr_cmd  (csr_cmd),
        .op1_data (op1_data),
        .imm_i    (imm_i),
        .rdata    (rdata),
        .req      (req),
        .wr       (wr)
    );

    csr_trap_unit u_trap (
        .clk                 (clk),
        .reset               (reset),
        .req                 (req),
        .wr                  (wr),
        .mcsr                (mcsr),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .tstate              (tstate),
        .cmd_out             (cmd_out),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    csr_read_mux u_read (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .mcsr        (mcsr),
        .tstate      (tstate),
        .cycle_count (cycle_count),
        .time_count  (time_count),
        .rdata       (rdata)
    );

    csr_machine_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regs (
        .clk   (clk),
        .reset (reset),
        .wr    (wr),
        .mcsr  (mcsr)
    );

endmodule

`default_nettype wire

// File: src/csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire csr_pkg::csr_req_t      req,
    input  wire csr_pkg::machine_csrs_t mcsr,
    input  wire csr_pkg::trap_state_t   tstate,
    input  wire logic [63:0]            cycle_count,
    input  wire logic [63:0]            time_count,
    output logic [31:0]                 rdata
);

    import csr_pkg::*;

    logic cycle_ok;
    logic time_ok;

    // Machine sees all, supervisor needs mcounteren, user needs both enables
    function automatic logic counter_visible(
        input priv_mode_e mode,
        input logic       m_en,
        input logic       s_en
    );
        return (mode == MODE_MACHINE) ||
               (m_en && (mode == MODE_SUPERVISOR || (mode == MODE_USER && s_en)));
    endfunction

    // Bit 0 is CY, bit 1 is TM
    assign cycle_ok = counter_visible(tstate.mode, mcsr.mcounteren[0], mcsr.scounteren[0]);
    assign time_ok  = counter_visible(tstate.mode, mcsr.mcounteren[1], mcsr.scounteren[1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            case (req.addr)
                CSR_ADDR_CYCLE: begin
                    rdata <= cycle_ok ? cycle_count[31:0] : 32'b0;
                end
                CSR_ADDR_CYCLEH: begin
                    rdata <= cycle_ok ? cycle_count[63:32] : 32'b0;
                end
                CSR_ADDR_TIME: begin
                    rdata <= time_ok ? time_count[31:0] : 32'b0;
                end
                CSR_ADDR_TIMEH: begin
                    rdata <= time_ok ? time_count[63:32] : 32'b0;
                end
                CSR_ADDR_MSTATUS:    rdata <= tstate.mstatus;
                CSR_ADDR_MIE:        rdata <= mcsr.mie;
                CSR_ADDR_MTVEC:      rdata <= mcsr.mtvec;
                CSR_ADDR_MCOUNTEREN: rdata <= {29'b0, mcsr.mcounteren};
                CSR_ADDR_SCOUNTEREN: rdata <= {29'b0, mcsr.scounteren};
                CSR_ADDR_MSCRATCH:   rdata <= mcsr.mscratch;
                CSR_ADDR_MEPC:       rdata <= tstate.mepc;
                CSR_ADDR_MCAUSE:     rdata <= tstate.mcause;
                CSR_ADDR_MTVAL:      rdata <= mcsr.mtval;
                // Anything not kept reads as zero
                default:             rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/csr_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire csr_pkg::csr_req_t      req,
    input  wire csr_pkg::csr_write_t    wr,
    input  wire csr_pkg::machine_csrs_t mcsr,
    input  wire logic [63:0]            mtime,
    input  wire logic [63:0]            mtimecmp,
    input  wire logic                   interrupt_ready,
    input  wire logic [31:0]            fetch_pc,
    output csr_pkg::trap_state_t        tstate,
    output csr_pkg::csr_cmd_e           cmd_out,
    output logic [31:0]                 trap_vector,
    output logic                        stall_may_interrupt
);

    import csr_pkg::*;

    priv_mode_e  mode;
    mstatus_t    mstatus;
    mstatus_t    wr_status;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic        timer_pending;
    logic        take_timer;
    logic        trap_entry;

    // MIE only masks while already in machine mode
    assign timer_pending = (mtime >= mtimecmp) && mcsr.mie.mtie &&
                           (mode != MODE_MACHINE || mstatus.mie);
    assign take_timer          = timer_pending && interrupt_ready;
    assign trap_entry          = take_timer || (req.cmd == CSR_ECALL);
    assign stall_may_interrupt = timer_pending;
    assign wr_status           = wr.data.mstatus;

    always_ff @(posedge clk) begin
        if (reset) begin
            mode        <= MODE_MACHINE;
            mstatus     <= '{mpp: MODE_MACHINE, default: '0};
            mepc        <= '0;
            mcause      <= '0;
            cmd_out     <= CSR_X;
            trap_vector <= '0;
        end else begin
            // Entry to machine mode, shared by timer and ECALL
            if (trap_entry) begin
                trap_vector  <= mcsr.mtvec;
                mode         <= MODE_MACHINE;
                mstatus.mpp  <= mode;
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
            end

            if (take_timer) begin
                // Interrupt replaces whatever request was presented
                cmd_out <= CSR_ECALL;
                mepc    <= fetch_pc;
                mcause  <= MCAUSE_MTIMER;
            end else begin
                cmd_out <= req.cmd;
                if (req.cmd == CSR_ECALL) begin
                    mcause <= MCAUSE_ECALL_BASE + {30'b0, mode};
                end
                if (req.cmd == CSR_MRET) begin
                    trap_vector  <= mepc;
                    mode         <= priv_mode_e'(mstatus.mpp);
                    mstatus.mpp  <= MODE_USER;
                    mstatus.mie  <= mstatus.mpie;
                    mstatus.mpie <= 1'b1;
                    if (mstatus.mpp != MODE_MACHINE) begin
                        mstatus.mprv <= 1'b0;
                    end
                end
            end

            // Software write lands last and so wins
            if (wr.en) begin
                case (wr.addr)
                    CSR_ADDR_MSTATUS: begin
                        mstatus.mprv <= wr_status.mprv;
                        mstatus.mpie <= wr_status.mpie;
                        mstatus.mie  <= wr_status.mie;
                        // Mode 2 is not implemented, so MPP keeps its value
                        if (wr_status.mpp != 2'b10) begin
                            mstatus.mpp <= wr_status.mpp;
                        end
                    end
                    CSR_ADDR_MEPC:   mepc   <= wr.data.raw;
                    CSR_ADDR_MCAUSE: mcause <= wr.data.raw;
                    default: ;
                endcase
            end
        end
    end

    assign tstate = '{mode: mode, mstatus: mstatus, mepc: mepc, mcause: mcause};

    // MRET restores from MPP, so MPP legalization keeps the mode valid
    a_mode_legal : assert property (@(posedge clk) disable iff (reset)
        mode != 2'b10);

endmodule

`default_nettype wire

// File: src/csr_command_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_command_stage (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               flush,
    input  wire csr_pkg::csr_cmd_e  csr_cmd,
    input  wire logic [31:0]        op1_data,
    input  wire logic [31:0]        imm_i,
    input  wire logic [31:0]        rdata,
    output csr_pkg::csr_req_t       req,
    output csr_pkg::csr_write_t     wr
);

    import csr_pkg::*;

    csr_cmd_e    save_cmd;
    logic [11:0] save_addr;
    logic [31:0] save_op1;
    logic [31:0] wdata;

    // Branch hazard in write-back turns the request into an empty read
    always_comb begin
        if (flush) begin
            req.cmd  = CSR_X;
            req.addr = 12'hfff;
            req.op1  = 32'hffff_ffff;
        end else begin
            req.cmd  = csr_cmd;
            req.addr = imm_i[11:0];
            req.op1  = op1_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            save_cmd <= CSR_X;
        end else begin
            save_cmd <= req.cmd;
        end
    end

    always_ff @(posedge clk) begin
        save_addr <= req.addr;
        save_op1  <= req.op1;
    end

    // rdata now holds the old value of the saved CSR
    always_comb begin
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = rdata | save_op1;
            CSR_C:   wdata = rdata & ~save_op1;
            default: wdata = '0;
        endcase
    end

    always_comb begin
        wr.en       = save_cmd inside {CSR_W, CSR_S, CSR_C};
        wr.addr     = save_addr;
        wr.data.raw = wdata;
    end

    // A committed write carries a known address and a known merged value
    a_write_known : assert property (@(posedge clk) disable iff (reset)
        wr.en |-> !$isunknown({wr.addr, wr.data.raw}));

endmodule

`default_nettype wire

// File: src/csr_machine_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire csr_pkg::csr_write_t wr,
    output csr_pkg::machine_csrs_t   mcsr
);

    import csr_pkg::*;

    // MEIE, MTIE and MSIE
    localparam logic [31:0] MIE_KEPT = 32'h0000_0888;

    mie_t mie_wr;

    // Only the three machine enables survive a write
    always_comb begin
        mie_wr      = '0;
        mie_wr.meie = wr.data.mie.meie;
        mie_wr.mtie = wr.data.mie.mtie;
        mie_wr.msie = wr.data.mie.msie;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcsr <= '{mtvec: MTVEC_RESET, default: '0};
        end else if (wr.en) begin
            case (wr.addr)
                CSR_ADDR_MTVEC:      mcsr.mtvec      <= wr.data.raw;
                CSR_ADDR_MSCRATCH:   mcsr.mscratch   <= wr.data.raw;
                CSR_ADDR_MTVAL:      mcsr.mtval      <= wr.data.raw;
                CSR_ADDR_MIE:        mcsr.mie        <= mie_wr;
                // IR, TM and CY
                CSR_ADDR_MCOUNTEREN: mcsr.mcounteren <= wr.data.raw[2:0];
                CSR_ADDR_SCOUNTEREN: mcsr.scounteren <= wr.data.raw[2:0];
                default: ;
            endcase
        end
    end

    // Supervisor and reserved enables never leak in from any write
    a_mie_reserved_zero : assert property (@(posedge clk) disable iff (reset)
        (mcsr.mie & ~MIE_KEPT) == 32'b0);

endmodule

`default_nettype wire

// File: src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Command codes coming from decode
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_e;

    typedef enum logic [1:0] {
        MODE_USER       = 2'b00,
        MODE_SUPERVISOR = 2'b01,
        MODE_MACHINE    = 2'b11
    } priv_mode_e;

    // Counters, read only
    localparam logic [11:0] CSR_ADDR_CYCLE      = 12'hc00;
    localparam logic [11:0] CSR_ADDR_TIME       = 12'hc01;
    localparam logic [11:0] CSR_ADDR_CYCLEH     = 12'hc80;
    localparam logic [11:0] CSR_ADDR_TIMEH      = 12'hc81;

    // Machine trap setup and handling
    localparam logic [11:0] CSR_ADDR_MSTATUS    = 12'h300;
    localparam logic [11:0] CSR_ADDR_MIE        = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC      = 12'h305;
    localparam logic [11:0] CSR_ADDR_MCOUNTEREN = 12'h306;
    localparam logic [11:0] CSR_ADDR_MSCRATCH   = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC       = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE     = 12'h342;
    localparam logic [11:0] CSR_ADDR_MTVAL      = 12'h343;
    localparam logic [11:0] CSR_ADDR_SCOUNTEREN = 12'h106;

    // Interrupt bit plus code 7
    localparam logic [31:0] MCAUSE_MTIMER       = 32'h8000_0007;
    // ECALL cause is this plus the current mode
    localparam logic [31:0] MCAUSE_ECALL_BASE   = 32'd8;

    typedef struct packed {
        logic [13:0] rsvd_31_18;
        logic        mprv;
        logic [3:0]  rsvd_16_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    typedef struct packed {
        logic [19:0] rsvd_31_12;
        logic        meie;
        logic [2:0]  rsvd_10_8;
        logic        mtie;
        logic [2:0]  rsvd_6_4;
        logic        msie;
        logic [2:0]  rsvd_2_0;
    } mie_t;

    // One write word, seen as mstatus or as mie depending on the target
    typedef union packed {
        logic [31:0] raw;
        mstatus_t    mstatus;
        mie_t        mie;
    } csr_word_u;

    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        logic [31:0] op1;
    } csr_req_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        csr_word_u   data;
    } csr_write_t;

    typedef struct packed {
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mtval;
        mie_t        mie;
        logic [2:0]  mcounteren;
        logic [2:0]  scounteren;
    } machine_csrs_t;

    typedef struct packed {
        priv_mode_e  mode;
        mstatus_t    mstatus;
        logic [31:0] mepc;
        logic [31:0] mcause;
    } trap_state_t;

endpackage

`default_nettype wire
